// File: filelist.f
+incdir+verif
common/id_pkg.sv
hw/id_queue.sv
decode/op_decoder.sv
decode/load_hazard.sv
decode/operand_select.sv
hw/id_stage.sv
verif/tb_id_stage.sv

// File: Bender.yml
package:
  name: id_stage

sources:
  - files:
      - common/id_pkg.sv
      - hw/id_queue.sv
      - decode/op_decoder.sv
      - decode/load_hazard.sv
      - decode/operand_select.sv
      - hw/id_stage.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/tb_id_stage.sv

// File: verif/tb_vectors.svh
// Decode table vectors
`ifndef tb_vectors_svh
`define tb_vectors_svh

// where the expected src_b comes from
localparam logic [2:0] sb_rs2     = 3'd0;
localparam logic [2:0] sb_mtvec   = 3'd1;
localparam logic [2:0] sb_mepc    = 3'd2;
localparam logic [2:0] sb_mcause  = 3'd3;
localparam logic [2:0] sb_mstatus = 3'd4;
localparam logic [2:0] sb_zero    = 3'd5;

typedef struct packed {
    logic [ilen-1:0]       inst;
    op_e                   op;
    logic                  wen;
    logic [reg_addr_w-1:0] rd;
    logic [xlen-1:0]       imm;
    logic [2:0]            src_b_sel;
} vec_t;

localparam int vec_n = 24;

// inst, op, wen, rd, sign-extended imm, src_b source
localparam vec_t vec_tab [vec_n] = '{
    '{32'hffb1_0093, op_addi,   1'b1, 5'd1,  64'hffff_ffff_ffff_fffb, sb_rs2},   // addi x1,x2,-5
    '{32'h8000_01b7, op_lui,    1'b1, 5'd3,  64'hffff_ffff_8000_0000, sb_rs2},   // lui x3,0x80000
    '{32'h1234_5217, op_auipc,  1'b1, 5'd4,  64'h0000_0000_1234_5000, sb_rs2},
    '{32'hff9f_f0ef, op_jal,    1'b1, 5'd1,  64'hffff_ffff_ffff_fff8, sb_rs2},   // jal x1,-8
    '{32'h0000_8067, op_jalr,   1'b1, 5'd0,  64'h0000_0000_0000_0000, sb_rs2},
    '{32'h0020_8863, op_beq,    1'b0, 5'd16, 64'h0000_0000_0000_0010, sb_rs2},   // beq x1,x2,16
    '{32'hfe41_9ee3, op_bne,    1'b0, 5'd29, 64'hffff_ffff_ffff_fffc, sb_rs2},   // bne x3,x4,-4
    '{32'h0081_3283, op_ld,     1'b1, 5'd5,  64'h0000_0000_0000_0008, sb_rs2},
    '{32'hfff3_e303, op_lwu,    1'b1, 5'd6,  64'hffff_ffff_ffff_ffff, sb_rs2},   // lwu x6,-1(x7)
    '{32'h0051_3823, op_sd,     1'b0, 5'd16, 64'h0000_0000_0000_0010, sb_rs2},   // sd x5,16(x2)
    '{32'hfe84_aa23, op_sw,     1'b0, 5'd20, 64'hffff_ffff_ffff_fff4, sb_rs2},   // sw x8,-12(x9)
    '{32'h4215_d513, op_srai,   1'b1, 5'd10, 64'h0000_0000_0000_0421, sb_rs2},   // shamt 33
    '{32'h0036_9613, op_slli,   1'b1, 5'd12, 64'h0000_0000_0000_0003, sb_rs2},
    '{32'h0107_8733, op_add,    1'b1, 5'd14, 64'h0000_0000_0000_0010, sb_rs2},   // add x14,x15,x16
    '{32'h4139_08b3, op_sub,    1'b1, 5'd17, 64'h0000_0000_0000_0413, sb_rs2},
    '{32'h016a_ba33, op_sltu,   1'b1, 5'd20, 64'h0000_0000_0000_0016, sb_rs2},
    '{32'h3000_22f3, op_csrrs,  1'b1, 5'd5,  64'h0000_0000_0000_0300, sb_mstatus},
    '{32'h3053_1073, op_csrrw,  1'b1, 5'd0,  64'h0000_0000_0000_0305, sb_mtvec},
    '{32'h3410_23f3, op_csrrs,  1'b1, 5'd7,  64'h0000_0000_0000_0341, sb_mepc},
    '{32'h3420_2473, op_csrrs,  1'b1, 5'd8,  64'h0000_0000_0000_0342, sb_mcause},
    '{32'hc000_24f3, op_csrrs,  1'b1, 5'd9,  64'hffff_ffff_ffff_fc00, sb_zero},  // cycle csr
    '{32'h0000_0073, op_ecall,  1'b0, 5'd0,  64'h0000_0000_0000_0000, sb_mtvec},
    '{32'h3020_0073, op_mret,   1'b0, 5'd0,  64'h0000_0000_0000_0302, sb_mepc},
    '{32'h0231_00b3, op_none,   1'b0, 5'd1,  64'h0000_0000_0000_0023, sb_rs2}    // mul, dropped
};

`endif

// File: verif/tb_id_stage.sv
// Decode stage testbench
`timescale 1ns/100ps

module tb_id_stage
    import id_pkg::*;
();

    `include "tb_vectors.svh"

    logic                  clk;
    logic                  arst_n;
    logic                  flush;
    logic                  valid_in;
    fetch_t                fetch_in;
    logic                  ready_in;
    logic                  ready_out;
    id_out_t               id_out;
    ex_info_t              ex_info;
    csr_state_t            csr;
    logic [reg_addr_w-1:0] rs1_addr;
    logic [reg_addr_w-1:0] rs2_addr;
    logic [xlen-1:0]       rs1_data;
    logic [xlen-1:0]       rs2_data;

    int unsigned errors;
    int unsigned checks;
    logic [31:0] seed;                                     // lcg state
    int          out_mode;                                 // 0 low, 1 high, 2 random
    logic        flush_req;                                // one-shot, taken at next drive
    ex_info_t    ex_next;
    id_out_t     got_q [$];                                // accepted outputs in order

    id_stage i_id_stage (
        .clk       (clk),
        .arst_n    (arst_n),
        .flush     (flush),
        .valid_in  (valid_in),
        .fetch_in  (fetch_in),
        .ready_in  (ready_in),
        .ready_out (ready_out),
        .id_out    (id_out),
        .ex_info   (ex_info),
        .csr       (csr),
        .rs1_addr  (rs1_addr),
        .rs2_addr  (rs2_addr),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data)
    );

    // register file model, address over its inverse
    function automatic logic [xlen-1:0] rf_read(input logic [reg_addr_w-1:0] addr);
        logic [31:0] a;
        a = 32'(addr);
        return {a, ~a};
    endfunction

    assign rs1_data = rf_read(rs1_addr);
    assign rs2_data = rf_read(rs2_addr);

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic logic [xlen-1:0] row_pc(input int i);
        return 64'h0000_0000_8000_0000 + 64'(i) * 64'd4;
    endfunction

    function automatic logic [xlen-1:0] exp_src_b(input vec_t v);
        case (v.src_b_sel)
            sb_mtvec:   return csr.mtvec;
            sb_mepc:    return csr.mepc;
            sb_mcause:  return csr.mcause;
            sb_mstatus: return csr.mstatus;
            sb_zero:    return '0;
            default:    return rf_read(v.inst[24:20]);     // register operand
        endcase
    endfunction

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;                            // 100 ns period
    end

    task automatic check_value(input string name, input logic [xlen-1:0] got,
                               input logic [xlen-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic report_and_finish();
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    endtask

    task automatic fail_timeout(input string what);
        $display("timed out waiting for %s at %0t", what, $time);
        errors++;
        report_and_finish();
    endtask

    // one clock, inputs at the falling edge, outputs sampled once settled
    task automatic drive_cycle(input logic v, input fetch_t f, output logic acc);
        logic [31:0] r;
        @(negedge clk);
        r         = lcg_next();
        acc       = v && ready_in;                         // honor ready_in
        valid_in  = acc;
        fetch_in  = f;
        flush     = flush_req;
        flush_req = 1'b0;
        ex_info   = ex_next;
        case (out_mode)
            0:       ready_out = 1'b0;
            1:       ready_out = 1'b1;
            default: ready_out = r[31];
        endcase
        #1;
        if (id_out.valid && ready_out) begin
            got_q.push_back(id_out);                       // taken at next rising edge
        end
    endtask

    task automatic idle_cycles(input int n);
        logic acc;
        repeat (n) drive_cycle(1'b0, '0, acc);
    endtask

    task automatic push_entry(input fetch_t f);
        logic acc;
        int   waited;
        acc    = 1'b0;
        waited = 0;
        while (!acc) begin
            if (waited == 200) fail_timeout("ready_in");
            drive_cycle(1'b1, f, acc);
            waited++;
        end
    endtask

    task automatic wait_for_outputs(input int n, input string what);
        int waited;
        waited = 0;
        while (got_q.size() < n) begin
            if (waited == 500) fail_timeout(what);
            idle_cycles(1);
            waited++;
        end
    endtask

    initial begin
        id_out_t o;
        fetch_t  f;
        int      waited;
        errors      = 0;
        checks      = 0;
        seed        = 32'hcd33_6515;
        out_mode    = 1;
        flush_req   = 1'b0;
        ex_next     = '0;
        arst_n      = 1'b0;
        flush       = 1'b0;
        valid_in    = 1'b0;
        fetch_in    = '0;
        ready_out   = 1'b0;
        ex_info     = '0;
        csr.mtvec   = 64'h0000_0000_8000_0100;             // distinct per csr
        csr.mepc    = 64'h0000_0000_8000_2468;
        csr.mcause  = 64'h8000_0000_0000_000b;
        csr.mstatus = 64'h0000_000a_0000_1880;
        repeat (5) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        #1;
        check_value("id_out.valid", id_out.valid, 1'b0);
        check_value("ready_in", ready_in, 1'b1);

        // decode table, execute always ready
        got_q.delete();
        for (int i = 0; i < vec_n; i++) begin
            f.pc   = row_pc(i);
            f.inst = vec_tab[i].inst;
            push_entry(f);
        end
        wait_for_outputs(vec_n, "decode table outputs");
        idle_cycles(4);
        check_value("table output count", got_q.size(), vec_n);
        for (int i = 0; i < vec_n; i++) begin
            o = got_q[i];
            check_value($sformatf("pc row %0d", i), o.pc, row_pc(i));
            check_value($sformatf("op row %0d", i), o.op, vec_tab[i].op);
            check_value($sformatf("wen row %0d", i), o.wen, vec_tab[i].wen);
            check_value($sformatf("rd row %0d", i), o.rd, vec_tab[i].rd);
            check_value($sformatf("imm row %0d", i), o.imm, vec_tab[i].imm);
            check_value($sformatf("src_a row %0d", i), o.src_a,
                        rf_read(vec_tab[i].inst[19:15]));
            check_value($sformatf("src_b row %0d", i), o.src_b, exp_src_b(vec_tab[i]));
        end

        // random back-pressure, order and pc kept
        got_q.delete();
        out_mode = 2;
        for (int i = 0; i < 40; i++) begin
            f.pc   = 64'h0000_0000_4000_0000 + 64'(i) * 64'd4;
            f.inst = {12'(i), 5'd1, 3'b000, 5'(i % 32), opc_op_imm};
            push_entry(f);
        end
        wait_for_outputs(40, "back-pressure outputs");
        idle_cycles(4);
        check_value("bp output count", got_q.size(), 40);
        for (int i = 0; i < 40; i++) begin
            check_value($sformatf("bp pc %0d", i), got_q[i].pc,
                        64'h0000_0000_4000_0000 + 64'(i) * 64'd4);
            check_value($sformatf("bp inst %0d", i), got_q[i].inst,
                        {12'(i), 5'd1, 3'b000, 5'(i % 32), opc_op_imm});
        end

        // almost-full with execute blocked
        got_q.delete();
        out_mode = 0;
        for (int i = 0; i < queue_alm_full; i++) begin
            f.pc   = 64'h0000_0000_5000_0000 + 64'(i) * 64'd4;
            f.inst = {12'(i), 5'd0, 3'b000, 5'd0, opc_op_imm};
            push_entry(f);
        end
        idle_cycles(1);
        check_value("ready_in at almost-full", ready_in, 1'b0);
        check_value("blocked output count", got_q.size(), 0);
        out_mode = 1;
        waited   = 0;
        while (!ready_in) begin
            if (waited == 50) fail_timeout("ready_in to rise");
            idle_cycles(1);
            waited++;
        end
        wait_for_outputs(queue_alm_full, "drained entries");
        for (int i = 0; i < queue_alm_full; i++) begin
            check_value($sformatf("drain pc %0d", i), got_q[i].pc,
                        64'h0000_0000_5000_0000 + 64'(i) * 64'd4);
        end

        // load-use interlock
        got_q.delete();
        ex_next.valid = 1'b1;
        ex_next.inst  = 32'h0001_3283;                     // ld x5,0(x2)
        f.pc          = 64'h0000_0000_6000_0000;
        f.inst        = 32'h0054_3023;                     // sd x5,0(x8), rs2 not compared
        push_entry(f);
        wait_for_outputs(1, "store past load");
        check_value("store pc", got_q[0].pc, 64'h0000_0000_6000_0000);
        f.pc   = 64'h0000_0000_6000_0004;
        f.inst = 32'h0072_8333;                            // add x6,x5,x7
        push_entry(f);
        idle_cycles(6);
        check_value("stalled output count", got_q.size(), 1);
        check_value("id_out.valid in stall", id_out.valid, 1'b0);
        ex_next = '0;                                      // load leaves execute
        wait_for_outputs(2, "add after stall");
        check_value("add pc", got_q[1].pc, 64'h0000_0000_6000_0004);
        check_value("add op", got_q[1].op, op_add);
        check_value("add src_a", got_q[1].src_a, rf_read(5'd5));

        // flush with slot stalled and entries queued
        got_q.delete();
        ex_next.valid = 1'b1;
        ex_next.inst  = 32'h0001_3283;
        for (int i = 0; i < 3; i++) begin
            f.pc   = 64'h0000_0000_7000_0000 + 64'(i) * 64'd4;
            f.inst = (i == 0) ? 32'h0072_8333 : {12'(i), 5'd0, 3'b000, 5'd0, opc_op_imm};
            push_entry(f);
        end
        idle_cycles(2);
        flush_req = 1'b1;
        idle_cycles(1);
        ex_next = '0;
        idle_cycles(6);
        check_value("flushed output count", got_q.size(), 0);
        for (int i = 0; i < 2; i++) begin
            f.pc   = 64'h0000_0000_7000_0100 + 64'(i) * 64'd4;
            f.inst = {12'(i), 5'd2, 3'b000, 5'd3, opc_op_imm};
            push_entry(f);
        end
        wait_for_outputs(2, "outputs after flush");
        check_value("post-flush pc 0", got_q[0].pc, 64'h0000_0000_7000_0100);
        check_value("post-flush pc 1", got_q[1].pc, 64'h0000_0000_7000_0104);

        report_and_finish();
    end

endmodule

// File: hw/id_stage.sv
// Instruction decode stage top
`timescale 1ns/100ps

module id_stage
    import id_pkg::*;
(
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  flush,
    input  logic                  valid_in,
    input  fetch_t                fetch_in,
    output logic                  ready_in,
    input  logic                  ready_out,
    output id_out_t               id_out,
    input  ex_info_t              ex_info,
    input  csr_state_t            csr,
    output logic [reg_addr_w-1:0] rs1_addr,
    output logic [reg_addr_w-1:0] rs2_addr,
    input  logic [xlen-1:0]       rs1_data,
    input  logic [xlen-1:0]       rs2_data
);

    slot_t   slot;                                         // registered decode slot
    decode_t dec;
    logic    stall;                                        // load-use interlock

    id_queue i_id_queue (
        .clk       (clk),
        .arst_n    (arst_n),
        .flush     (flush),
        .valid_in  (valid_in),
        .fetch_in  (fetch_in),
        .ready_in  (ready_in),
        .ready_out (ready_out),
        .stall     (stall),
        .slot      (slot)
    );

    op_decoder i_op_decoder (
        .slot (slot),
        .dec  (dec)
    );

    load_hazard i_load_hazard (
        .slot    (slot),
        .ex_info (ex_info),
        .stall   (stall)
    );

    operand_select i_operand_select (
        .slot     (slot),
        .dec      (dec),
        .stall    (stall),
        .csr      (csr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .id_out   (id_out)
    );

endmodule

// File: decode/operand_select.sv
// Immediate and operand selection
`timescale 1ns/100ps

module operand_select
    import id_pkg::*;
(
    input  slot_t                  slot,
    input  decode_t                dec,
    input  logic                   stall,
    input  csr_state_t             csr,
    input  logic [xlen-1:0]        rs1_data,
    input  logic [xlen-1:0]        rs2_data,
    output logic [reg_addr_w-1:0]  rs1_addr,
    output logic [reg_addr_w-1:0]  rs2_addr,
    output id_out_t                id_out
);

    logic [ilen-1:0] inst;
    logic            sign;
    logic [xlen-1:0] imm;
    logic [xlen-1:0] csr_val;
    logic [xlen-1:0] src_b;

    assign inst     = slot.fetch.inst;
    assign sign     = inst[31];                            // all formats sign from bit 31
    assign rs1_addr = inst[19:15];                         // to external regfile
    assign rs2_addr = inst[24:20];

    always_comb begin
        case (dec.imm_fmt)
            fmt_s:   imm = {{(xlen-12){sign}}, inst[31:25], inst[11:7]};
            fmt_b:   imm = {{(xlen-12){sign}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            fmt_u:   imm = {{(xlen-32){sign}}, inst[31:12], 12'b0};
            fmt_j:   imm = {{(xlen-20){sign}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            default: imm = {{(xlen-12){sign}}, inst[31:20]}; // fmt_i
        endcase
    end

    // csr number sits in the i-immediate field
    always_comb begin
        case (inst[31:20])
            csr_mtvec_addr:   csr_val = csr.mtvec;
            csr_mepc_addr:    csr_val = csr.mepc;
            csr_mcause_addr:  csr_val = csr.mcause;
            csr_mstatus_addr: csr_val = csr.mstatus;
            default:          csr_val = '0;                // unimplemented csr reads zero
        endcase
    end

    always_comb begin
        case (dec.op)
            op_csrrw, op_csrrs: src_b = csr_val;
            op_ecall:           src_b = csr.mtvec;         // trap target
            op_mret:            src_b = csr.mepc;          // return address
            default:            src_b = rs2_data;
        endcase
    end

    always_comb begin
        id_out.valid = slot.valid && !stall;               // bubble while waiting on load
        id_out.pc    = slot.fetch.pc;
        id_out.inst  = inst;
        id_out.op    = dec.op;
        id_out.rd    = dec.rd;
        id_out.wen   = dec.wen;
        id_out.src_a = rs1_data;
        id_out.src_b = src_b;
        id_out.imm   = imm;
    end

endmodule

// File: decode/load_hazard.sv
// Load-use hazard detection
`timescale 1ns/100ps

module load_hazard
    import id_pkg::*;
(
    input  slot_t    slot,
    input  ex_info_t ex_info,
    output logic     stall
);

    logic [reg_addr_w-1:0] ex_rd;
    logic [reg_addr_w-1:0] rs1;
    logic [reg_addr_w-1:0] rs2;
    logic                  ex_is_load;
    logic                  rs2_used;
    logic                  rs1_hit;
    logic                  rs2_hit;

    assign ex_rd = ex_info.inst[11:7];
    assign rs1   = slot.fetch.inst[19:15];
    assign rs2   = slot.fetch.inst[24:20];

    always_comb begin
        ex_is_load = 1'b0;
        if (ex_info.inst[6:0] == opc_load) begin
            case (ex_info.inst[14:12])
                3'b000, 3'b001, 3'b010, 3'b011: ex_is_load = 1'b1; // lb lh lw ld
                3'b100, 3'b101, 3'b110:         ex_is_load = 1'b1; // lbu lhu lwu
                default:                        ex_is_load = 1'b0;
            endcase
        end
    end

    // only branches and reg-reg ops read rs2 as an operand here
    assign rs2_used = (slot.fetch.inst[6:0] == opc_branch) ||
                      (slot.fetch.inst[6:0] == opc_op);

    assign rs1_hit = (ex_rd == rs1);
    assign rs2_hit = (ex_rd == rs2) && rs2_used;

    assign stall = slot.valid && ex_info.valid && ex_is_load && (rs1_hit || rs2_hit);

endmodule

// File: decode/op_decoder.sv
// Instruction opcode decoder
`timescale 1ns/100ps

module op_decoder
    import id_pkg::*;
(
    input  slot_t   slot,
    output decode_t dec
);

    logic [ilen-1:0] inst;
    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    op_e             op;
    imm_fmt_e        imm_fmt;
    logic            wen;

    assign inst   = slot.fetch.inst;
    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    always_comb begin
        op      = op_none;
        imm_fmt = fmt_i;                                   // default format
        if (slot.valid) begin
            case (opcode)
                opc_lui: begin
                    op      = op_lui;
                    imm_fmt = fmt_u;
                end
                opc_auipc: begin
                    op      = op_auipc;
                    imm_fmt = fmt_u;
                end
                opc_jal: begin
                    op      = op_jal;
                    imm_fmt = fmt_j;
                end
                opc_jalr: begin
                    if (funct3 == 3'b000) op = op_jalr;
                end
                opc_branch: begin
                    imm_fmt = fmt_b;
                    case (funct3)
                        3'b000:  op = op_beq;
                        3'b001:  op = op_bne;
                        3'b100:  op = op_blt;
                        3'b101:  op = op_bge;
                        3'b110:  op = op_bltu;
                        3'b111:  op = op_bgeu;
                        default: op = op_none;
                    endcase
                end
                opc_load: begin
                    case (funct3)
                        3'b000:  op = op_lb;
                        3'b001:  op = op_lh;
                        3'b010:  op = op_lw;
                        3'b011:  op = op_ld;
                        3'b100:  op = op_lbu;
                        3'b101:  op = op_lhu;
                        3'b110:  op = op_lwu;
                        default: op = op_none;
                    endcase
                end
                opc_store: begin
                    imm_fmt = fmt_s;
                    case (funct3)
                        3'b000:  op = op_sb;
                        3'b001:  op = op_sh;
                        3'b010:  op = op_sw;
                        3'b011:  op = op_sd;
                        default: op = op_none;
                    endcase
                end
                opc_op_imm: begin
                    case (funct3)
                        3'b000:  op = op_addi;
                        3'b010:  op = op_slti;
                        3'b011:  op = op_sltiu;
                        3'b100:  op = op_xori;
                        3'b110:  op = op_ori;
                        3'b111:  op = op_andi;
                        3'b001:  op = (inst[31:26] == 6'b000000) ? op_slli : op_none;
                        3'b101: begin                      // 6-bit shamt on rv64
                            if (inst[31:26] == 6'b000000)      op = op_srli;
                            else if (inst[31:26] == 6'b010000) op = op_srai;
                        end
                        default: op = op_none;
                    endcase
                end
                opc_op: begin
                    case ({funct7, funct3})
                        10'b0000000_000: op = op_add;
                        10'b0100000_000: op = op_sub;
                        10'b0000000_001: op = op_sll;
                        10'b0000000_010: op = op_slt;
                        10'b0000000_011: op = op_sltu;
                        10'b0000000_100: op = op_xor;
                        10'b0000000_101: op = op_srl;
                        10'b0100000_101: op = op_sra;
                        10'b0000000_110: op = op_or;
                        10'b0000000_111: op = op_and;
                        default:         op = op_none; // m-extension not decoded
                    endcase
                end
                opc_system: begin
                    if (inst == inst_ecall)     op = op_ecall;
                    else if (inst == inst_mret) op = op_mret;
                    else if (funct3 == 3'b001)  op = op_csrrw;
                    else if (funct3 == 3'b010)  op = op_csrrs;
                end
                default: op = op_none;
            endcase
        end
    end

    // no rd write for branches, stores, trap ops or unknowns
    always_comb begin
        case (op)
            op_none, op_ecall, op_mret,
            op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu,
            op_sb, op_sh, op_sw, op_sd: wen = 1'b0;
            default:                    wen = 1'b1;
        endcase
    end

    assign dec = '{op: op, imm_fmt: imm_fmt, wen: wen, rd: inst[11:7]};

endmodule

// File: hw/id_queue.sv
// Fetch queue and decode slot
`timescale 1ns/100ps

module id_queue
    import id_pkg::*;
(
    input  logic   clk,
    input  logic   arst_n,
    input  logic   flush,      // branch flush, empties queue and slot
    input  logic   valid_in,
    input  fetch_t fetch_in,
    output logic   ready_in,
    input  logic   ready_out,
    input  logic   stall,
    output slot_t  slot
);

    fetch_t                 mem [queue_depth];      // entry storage
    logic [queue_ptr_w-1:0] rd_ptr;
    logic [queue_ptr_w-1:0] wr_ptr;
    logic [queue_cnt_w-1:0] count;
    logic                   advance;
    logic                   empty;
    logic                   full;
    logic                   push;
    logic                   pop;

    assign advance  = ready_out && !stall;                 // stage moves on
    assign empty    = (count == '0);
    assign full     = (count == queue_cnt_w'(queue_depth));
    assign push     = valid_in && !full;                   // write into full queue is dropped
    assign pop      = advance && !empty;
    assign ready_in = (count < queue_cnt_w'(queue_alm_full));

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= fetch_in;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            rd_ptr <= '0;                                  // same-cycle write lost too
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;                   // wraps at depth
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;                   // none or both
            endcase
        end
    end

    // decode slot, loads head on advance
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            slot <= '0;
        end else if (flush) begin
            slot <= '0;
        end else if (advance) begin
            if (empty) begin
                slot <= '0;                                // bubble
            end else begin
                slot.valid <= 1'b1;
                slot.fetch <= mem[rd_ptr];
            end
        end
    end

endmodule

// File: common/id_pkg.sv
// Decode stage shared definitions
package id_pkg;

    // widths
    localparam int xlen       = 64;
    localparam int ilen       = 32;
    localparam int reg_addr_w = 5;

    // instruction queue
    localparam int queue_depth    = 16;
    localparam int queue_alm_full = 12;                    // ready_in drops at this count
    localparam int queue_ptr_w    = $clog2(queue_depth);
    localparam int queue_cnt_w    = $clog2(queue_depth + 1); // needs to hold full count

    // machine csr numbers
    localparam logic [11:0] csr_mtvec_addr   = 12'h305;
    localparam logic [11:0] csr_mepc_addr    = 12'h341;
    localparam logic [11:0] csr_mcause_addr  = 12'h342;
    localparam logic [11:0] csr_mstatus_addr = 12'h300;

    // full encodings, no operand fields
    localparam logic [ilen-1:0] inst_ecall = 32'h0000_0073;
    localparam logic [ilen-1:0] inst_mret  = 32'h3020_0073;

    // major opcodes, inst[6:0]
    localparam logic [6:0] opc_load   = 7'b000_0011;
    localparam logic [6:0] opc_store  = 7'b010_0011;
    localparam logic [6:0] opc_branch = 7'b110_0011;
    localparam logic [6:0] opc_jalr   = 7'b110_0111;
    localparam logic [6:0] opc_jal    = 7'b110_1111;
    localparam logic [6:0] opc_op     = 7'b011_0011;
    localparam logic [6:0] opc_op_imm = 7'b001_0011;
    localparam logic [6:0] opc_lui    = 7'b011_0111;
    localparam logic [6:0] opc_auipc  = 7'b001_0111;
    localparam logic [6:0] opc_system = 7'b111_0011;

    typedef enum logic [7:0] {
        op_none,                                           // invalid slot or unknown encoding
        op_lui, op_auipc, op_jal, op_jalr,
        op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu,
        op_lb, op_lh, op_lw, op_ld, op_lbu, op_lhu, op_lwu,
        op_sb, op_sh, op_sw, op_sd,
        op_addi, op_slti, op_sltiu, op_xori, op_ori, op_andi,
        op_slli, op_srli, op_srai,
        op_add, op_sub, op_sll, op_slt, op_sltu,
        op_xor, op_srl, op_sra, op_or, op_and,
        op_csrrw, op_csrrs,                                // csr read into src_b
        op_ecall, op_mret                                  // trap entry / return
    } op_e;

    typedef enum logic [2:0] {
        fmt_i,
        fmt_s,
        fmt_b,
        fmt_u,
        fmt_j
    } imm_fmt_e;

    // one queue entry, also the fetch input
    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [ilen-1:0] inst;
    } fetch_t;

    // decode slot register
    typedef struct packed {
        logic   valid;
        fetch_t fetch;
    } slot_t;

    // instruction currently in execute
    typedef struct packed {
        logic            valid;
        logic [ilen-1:0] inst;
    } ex_info_t;

    typedef struct packed {
        logic [xlen-1:0] mtvec;
        logic [xlen-1:0] mepc;
        logic [xlen-1:0] mcause;
        logic [xlen-1:0] mstatus;
    } csr_state_t;

    // decoder result
    typedef struct packed {
        op_e                   op;
        imm_fmt_e              imm_fmt;
        logic                  wen;                        // writes rd
        logic [reg_addr_w-1:0] rd;
    } decode_t;

    // towards execute
    typedef struct packed {
        logic                  valid;
        logic [xlen-1:0]       pc;
        logic [ilen-1:0]       inst;
        op_e                   op;
        logic [reg_addr_w-1:0] rd;
        logic                  wen;
        logic [xlen-1:0]       src_a;
        logic [xlen-1:0]       src_b;
        logic [xlen-1:0]       imm;
    } id_out_t;

endpackage
